// File: project.f
hdl/spi_frame_pkg.sv
hdl/reg_map_pkg.sv
hdl/spi_frame_rx.sv
hdl/reg_bank.sv
hdl/sr4094_driver.sv
hdl/register_set_top.sv
tests/register_set_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= register_set_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || { echo "simulation ended without a pass line"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/register_set_tb.sv
// testbench for the register set: clock, reset, SPI master, 4094 chain model, frame table, checks
`default_nettype none

module register_set_tb;
  import spi_frame_pkg::*;
  import reg_map_pkg::*;

  localparam int HALF_SCLK = 6;
  localparam int MAX_ROWS  = 64;
  localparam int TIMEOUT   = 2000;

  logic  clk = 1'b0;
  logic  arst_n;
  logic  spi_clk;
  logic  spi_cs_n;
  logic  spi_sdi;
  logic  spi_sdo;
  data_t reg_led;
  data_t reg_spi_mux;
  data_t reg_mode;
  data_t reg_direct;
  logic  sr_clk;
  logic  sr_data;
  logic  sr_strobe;
  logic  sr_oe;

  // 4094 chain model state
  // chain powers up all ones like an undefined 4094
  data_t chain_word = '1;
  data_t sr_word = '0;
  int    strobe_cnt = 0;

  // frame table with one entry per row
  logic    row_rd [0:MAX_ROWS-1];
  spi_op_e row_op [0:MAX_ROWS-1];
  addr_t   row_addr [0:MAX_ROWS-1];
  data_t   row_data [0:MAX_ROWS-1];
  int      row_abort [0:MAX_ROWS-1];
  data_t   row_exp_rb [0:MAX_ROWS-1];
  logic    row_sr_chg [0:MAX_ROWS-1];
  // expected register contents after each row in map_addr slot order
  data_t   exp_regs [0:MAX_ROWS-1][0:4];
  int      n_rows = 0;

  // shadow of the five registers while the table is built
  data_t model_regs [0:4];
  addr_t map_addr [0:4];
  logic [31:0] lcg_state = 32'hc392;

  register_set_top #(
    .SR_BITS (32),
    .SR_DIV  (4)
  ) u_dut (
    .clk         (clk),
    .arst_n      (arst_n),
    .spi_clk     (spi_clk),
    .spi_cs_n    (spi_cs_n),
    .spi_sdi     (spi_sdi),
    .spi_sdo     (spi_sdo),
    .reg_led     (reg_led),
    .reg_spi_mux (reg_spi_mux),
    .reg_mode    (reg_mode),
    .reg_direct  (reg_direct),
    .sr_clk      (sr_clk),
    .sr_data     (sr_data),
    .sr_strobe   (sr_strobe),
    .sr_oe       (sr_oe)
  );

  always #5 clk = ~clk;

  // chain shifts on sr_clk rise and its output latch follows the strobe
  always @(posedge sr_clk)
    chain_word <= {chain_word[30:0], sr_data};

  always @(posedge sr_strobe)
  begin
    sr_word    <= chain_word;
    strobe_cnt <= strobe_cnt + 1;
  end

  function automatic data_t next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // shadow slot of an address or -1 when nothing is mapped there
  function automatic int slot_of(input addr_t a);
    for (int s = 0; s < 5; s++)
      if (map_addr[s] == a)
        return s;
    return -1;
  endfunction

  // or, and-not, xor or plain replace
  function automatic data_t model_update(input spi_op_e op, input data_t cur, input data_t arg);
    if (op == op_set)
      return cur | arg;
    if (op == op_clear)
      return cur & ~arg;
    if (op == op_toggle)
      return cur ^ arg;
    return arg;
  endfunction

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp)
      stop_on_error($sformatf("error: %s = 0x%08h, expected 0x%08h", name, got, exp));
  endtask

  task automatic check_sr(input data_t got, input data_t exp);
    if (got !== exp)
      stop_on_error($sformatf("error: 4094 latched word = 0x%08h, expected 0x%08h", got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_on_error($sformatf("error: %s = 0x%h, expected 0x%h", name, got, exp));
  endtask

  // n clk edges and then 1 unit into the cycle for driving
  task automatic advance_clks(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic wait_strobes(input int target);
    int n;
    for (n = 0; n < TIMEOUT && strobe_cnt < target; n++)
      advance_clks(1);
    if (strobe_cnt < target)
      stop_on_error("timeout: the 4094 chain was never latched by sr_strobe");
  endtask

  task automatic wait_strobe_end();
    int n;
    for (n = 0; n < TIMEOUT && sr_strobe; n++)
      advance_clks(1);
    if (sr_strobe)
      stop_on_error("timeout: sr_strobe never returned low");
  endtask

  // mode 0 frame with sdo captured on each spi_clk rise from bit 9 on
  task automatic run_frame(input logic rd, input spi_op_e op, input addr_t addr,
                           input data_t data, input int abort_bits, output data_t rb);
    logic [39:0] word;
    int nbits;
    int i;
    word  = {rd, op, addr, data};
    nbits = (abort_bits == 0) ? 40 : abort_bits;
    rb    = '0;
    spi_cs_n = 1'b0;
    for (i = 0; i < nbits; i++)
    begin
      spi_sdi = word[39-i];
      advance_clks(HALF_SCLK);
      spi_clk = 1'b1;
      if (i >= 8)
        rb = {rb[30:0], spi_sdo};
      advance_clks(HALF_SCLK);
      spi_clk = 1'b0;
    end
    advance_clks(HALF_SCLK);
    spi_cs_n = 1'b1;
    spi_sdi  = 1'b0;
    advance_clks(HALF_SCLK);
  endtask

  // appends a row whose expected readback is the old word of the target
  task automatic add_row(input logic rd, input spi_op_e op, input addr_t addr,
                         input data_t data, input int abort_bits);
    int s;
    int k;
    data_t old_word;
    s = slot_of(addr);
    old_word = (s < 0) ? UNMAPPED_READ : model_regs[s];
    row_rd[n_rows]     = rd;
    row_op[n_rows]     = op;
    row_addr[n_rows]   = addr;
    row_data[n_rows]   = data;
    row_abort[n_rows]  = abort_bits;
    row_exp_rb[n_rows] = old_word;
    row_sr_chg[n_rows] = 1'b0;
    // only complete write frames to a mapped address take effect
    if (!rd && abort_bits == 0 && s >= 0)
    begin
      model_regs[s] = model_update(op, old_word, data);
      row_sr_chg[n_rows] = (s == 2) && (model_regs[s] != old_word);
    end
    for (k = 0; k < 5; k++)
      exp_regs[n_rows][k] = model_regs[k];
    n_rows++;
  endtask

  initial
  begin
    int r;
    int k;
    int base;
    data_t rb;
    arst_n   = 1'b0;
    spi_clk  = 1'b0;
    spi_cs_n = 1'b1;
    spi_sdi  = 1'b0;
    map_addr[0] = REG_LED;
    map_addr[1] = REG_SPI_MUX;
    map_addr[2] = REG_4094;
    map_addr[3] = REG_MODE;
    map_addr[4] = REG_DIRECT;
    model_regs[0] = RST_LED;
    model_regs[1] = RST_SPI_MUX;
    model_regs[2] = RST_4094;
    model_regs[3] = RST_MODE;
    model_regs[4] = RST_DIRECT;

    // reset values and then random writes read back
    for (k = 0; k < 5; k++)
      add_row(1'b1, op_write, map_addr[k], '0, 0);
    for (k = 0; k < 5; k++)
      add_row(1'b0, op_write, map_addr[k], next_rand(), 0);
    for (k = 0; k < 5; k++)
      add_row(1'b1, op_write, map_addr[k], '0, 0);
    // bitwise updates on every register
    for (k = 0; k < 5; k++)
    begin
      add_row(1'b0, op_set, map_addr[k], next_rand(), 0);
      add_row(1'b0, op_clear, map_addr[k], next_rand(), 0);
      add_row(1'b0, op_toggle, map_addr[k], next_rand(), 0);
    end
    // read flag blocks the write and unmapped addresses read the pattern
    add_row(1'b1, op_write, REG_LED, next_rand(), 0);
    add_row(1'b1, op_set, REG_MODE, next_rand(), 0);
    add_row(1'b1, op_write, 5'd3, '0, 0);
    add_row(1'b0, op_write, 5'd20, next_rand(), 0);
    add_row(1'b0, op_toggle, 5'd31, next_rand(), 0);
    for (k = 0; k < 5; k++)
      add_row(1'b1, op_write, map_addr[k], '0, 0);
    // frame cut after 20 bits and then a normal write and read
    add_row(1'b0, op_write, REG_SPI_MUX, next_rand(), 20);
    add_row(1'b0, op_write, REG_SPI_MUX, next_rand(), 0);
    add_row(1'b1, op_write, REG_SPI_MUX, '0, 0);

    advance_clks(2);
    arst_n = 1'b1;

    // outputs idle before the first transfer
    check_bit("sr_oe", sr_oe, 1'b0);
    check_bit("spi_sdo", spi_sdo, 1'b0);

    // the driver pushes the reset value into the chain by itself
    wait_strobes(1);
    check_sr(sr_word, RST_4094);
    wait_strobe_end();
    check_bit("sr_oe", sr_oe, 1'b1);

    for (r = 0; r < n_rows; r++)
    begin
      run_frame(row_rd[r], row_op[r], row_addr[r], row_data[r], row_abort[r], rb);
      if (row_abort[r] == 0)
        check_data("spi_sdo readback", rb, row_exp_rb[r]);
      check_data("reg_led", reg_led, exp_regs[r][0]);
      check_data("reg_spi_mux", reg_spi_mux, exp_regs[r][1]);
      check_data("reg_mode", reg_mode, exp_regs[r][3]);
      check_data("reg_direct", reg_direct, exp_regs[r][4]);
      // new 4094 value has to reach the chain latch
      if (row_sr_chg[r])
      begin
        base = strobe_cnt;
        wait_strobes(base + 1);
        check_sr(sr_word, exp_regs[r][2]);
        check_bit("sr_oe", sr_oe, 1'b1);
      end
    end

    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/register_set_top.sv
// register set top level: SPI frame receiver, register bank and 4094 driver
`default_nettype none

module register_set_top #(
  parameter int SR_BITS = 32,
  parameter int SR_DIV  = 4
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 spi_clk,
  input  logic                 spi_cs_n,
  input  logic                 spi_sdi,
  output logic                 spi_sdo,
  output spi_frame_pkg::data_t reg_led,
  output spi_frame_pkg::data_t reg_spi_mux,
  output spi_frame_pkg::data_t reg_mode,
  output spi_frame_pkg::data_t reg_direct,
  output logic                 sr_clk,
  output logic                 sr_data,
  output logic                 sr_strobe,
  output logic                 sr_oe
);
  import spi_frame_pkg::*;

  // receiver to register bank
  logic    cmd_strobe;
  addr_t   cmd_addr;
  logic    frame_strobe;
  logic    frame_read;
  spi_op_e frame_op;
  data_t   frame_data;

  // register bank back to the receiver
  data_t rd_data;
  // state word for the 4094 chain
  data_t reg_4094;

  spi_frame_rx u_rx (
    .clk          (clk),
    .arst_n       (arst_n),
    .spi_clk      (spi_clk),
    .spi_cs_n     (spi_cs_n),
    .spi_sdi      (spi_sdi),
    .rd_data      (rd_data),
    .spi_sdo      (spi_sdo),
    .cmd_strobe   (cmd_strobe),
    .cmd_addr     (cmd_addr),
    .frame_strobe (frame_strobe),
    .frame_read   (frame_read),
    .frame_op     (frame_op),
    .frame_data   (frame_data)
  );

  reg_bank u_regs (
    .clk          (clk),
    .arst_n       (arst_n),
    .cmd_strobe   (cmd_strobe),
    .cmd_addr     (cmd_addr),
    .frame_strobe (frame_strobe),
    .frame_read   (frame_read),
    .frame_op     (frame_op),
    .frame_data   (frame_data),
    .rd_data      (rd_data),
    .reg_led      (reg_led),
    .reg_spi_mux  (reg_spi_mux),
    .reg_4094     (reg_4094),
    .reg_mode     (reg_mode),
    .reg_direct   (reg_direct)
  );

  sr4094_driver #(
    .SR_BITS (SR_BITS),
    .SR_DIV  (SR_DIV)
  ) u_sr (
    .clk       (clk),
    .arst_n    (arst_n),
    .reg_4094  (reg_4094),
    .sr_clk    (sr_clk),
    .sr_data   (sr_data),
    .sr_strobe (sr_strobe),
    .sr_oe     (sr_oe)
  );

endmodule

`default_nettype wire

// File: hdl/sr4094_driver.sv
// 4094 chain driver: change detect, clock divider, shift FSM, strobe and output enable
`default_nettype none

module sr4094_driver #(
  parameter int SR_BITS = 32,
  parameter int SR_DIV  = 4
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  spi_frame_pkg::data_t reg_4094,
  output logic                 sr_clk,
  output logic                 sr_data,
  output logic                 sr_strobe,
  output logic                 sr_oe
);

  localparam int BIT_W = $clog2(SR_BITS);
  localparam int DIV_W = (SR_DIV > 1) ? $clog2(SR_DIV) : 1;
  localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(SR_BITS - 1);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SR_DIV - 1);

  typedef enum logic [1:0] {
    st_idle,
    st_shift,
    st_latch
  } sr_state_e;

  sr_state_e state;

  // word most recently loaded into the chain
  logic [SR_BITS-1:0] sent_word;
  logic [SR_BITS-1:0] shift_word;
  logic [SR_BITS-1:0] new_word;
  logic [BIT_W-1:0]   bit_cnt;
  logic [DIV_W-1:0]   div_cnt;
  // forces one transfer after reset
  logic init_pend;
  logic div_tick;

  // only the low bits reach the chain
  assign new_word = reg_4094[SR_BITS-1:0];
  // end of one sr_clk half period
  assign div_tick = (div_cnt == DIV_LAST);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state      <= st_idle;
      sent_word  <= '0;
      shift_word <= '0;
      bit_cnt    <= '0;
      div_cnt    <= '0;
      init_pend  <= 1'b1;
      sr_clk     <= 1'b0;
      sr_data    <= 1'b0;
      sr_strobe  <= 1'b0;
      sr_oe      <= 1'b0;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          div_cnt <= '0;
          // newest value wins, intermediate ones may be skipped
          if (init_pend || (new_word != sent_word))
          begin
            init_pend  <= 1'b0;
            sent_word  <= new_word;
            shift_word <= new_word;
            // MSB set up while sr_clk is low
            sr_data    <= new_word[SR_BITS-1];
            bit_cnt    <= '0;
            state      <= st_shift;
          end
        end
        st_shift:
        begin
          div_cnt <= div_tick ? '0 : div_cnt + 1'b1;
          if (div_tick)
          begin
            if (!sr_clk)
              // chain captures sr_data here
              sr_clk <= 1'b1;
            else
            begin
              sr_clk <= 1'b0;
              if (bit_cnt == LAST_BIT)
              begin
                sr_strobe <= 1'b1;
                state     <= st_latch;
              end
              else
              begin
                // next bit changes on the falling sr_clk
                bit_cnt    <= bit_cnt + 1'b1;
                shift_word <= {shift_word[SR_BITS-2:0], 1'b0};
                sr_data    <= shift_word[SR_BITS-2];
              end
            end
          end
        end
        st_latch:
        begin
          div_cnt <= div_tick ? '0 : div_cnt + 1'b1;
          // strobe held for one half period
          if (div_tick)
          begin
            sr_strobe <= 1'b0;
            // outputs valid once the first word is latched
            sr_oe     <= 1'b1;
            state     <= st_idle;
          end
        end
        default:
          state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/reg_bank.sv
// register bank: five control registers, readback mux and write, set, clear, toggle update
`default_nettype none

module reg_bank (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   cmd_strobe,
  input  spi_frame_pkg::addr_t   cmd_addr,
  input  logic                   frame_strobe,
  input  logic                   frame_read,
  input  spi_frame_pkg::spi_op_e frame_op,
  input  spi_frame_pkg::data_t   frame_data,
  output spi_frame_pkg::data_t   rd_data,
  output spi_frame_pkg::data_t   reg_led,
  output spi_frame_pkg::data_t   reg_spi_mux,
  output spi_frame_pkg::data_t   reg_4094,
  output spi_frame_pkg::data_t   reg_mode,
  output spi_frame_pkg::data_t   reg_direct
);
  import spi_frame_pkg::*;
  import reg_map_pkg::*;

  // new register value from the opcode, the current value and the frame data
  function automatic data_t apply_op(input spi_op_e op, input data_t cur, input data_t arg);
    data_t res;
    case (op)
      op_set:    res = cur | arg;
      op_clear:  res = cur & ~arg;
      op_toggle: res = cur ^ arg;
      default:   res = arg;
    endcase
    return res;
  endfunction

  logic  do_write;
  data_t cur_word;
  data_t next_word;

  // read-flagged frames leave everything alone
  assign do_write = frame_strobe & ~frame_read;

  // addressed register, shared by readback and update
  always_comb
  begin
    case (cmd_addr)
      REG_LED:     cur_word = reg_led;
      REG_SPI_MUX: cur_word = reg_spi_mux;
      REG_4094:    cur_word = reg_4094;
      REG_MODE:    cur_word = reg_mode;
      REG_DIRECT:  cur_word = reg_direct;
      default:     cur_word = UNMAPPED_READ;
    endcase
  end

  assign next_word = apply_op(frame_op, cur_word, frame_data);

  // readback captured at bit 8, held until the next command
  always_ff @(posedge clk)
  begin
    if (cmd_strobe)
      rd_data <= cur_word;
  end

  // register update at the end of a full frame
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      reg_led     <= RST_LED;
      reg_spi_mux <= RST_SPI_MUX;
      reg_4094    <= RST_4094;
      reg_mode    <= RST_MODE;
      reg_direct  <= RST_DIRECT;
    end
    else if (do_write)
    begin
      // cmd_addr still holds the address latched at bit 8
      case (cmd_addr)
        REG_LED:     reg_led     <= next_word;
        REG_SPI_MUX: reg_spi_mux <= next_word;
        REG_4094:    reg_4094    <= next_word;
        REG_MODE:    reg_mode    <= next_word;
        REG_DIRECT:  reg_direct  <= next_word;
        // unmapped addresses take no write
        default:
        begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/spi_frame_rx.sv
// SPI mode 0 frame receiver: pin synchronizers, edge detect, bit counter, shifters, strobes
`default_nettype none

module spi_frame_rx (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   spi_clk,
  input  logic                   spi_cs_n,
  input  logic                   spi_sdi,
  input  spi_frame_pkg::data_t   rd_data,
  output logic                   spi_sdo,
  output logic                   cmd_strobe,
  output spi_frame_pkg::addr_t   cmd_addr,
  output logic                   frame_strobe,
  output logic                   frame_read,
  output spi_frame_pkg::spi_op_e frame_op,
  output spi_frame_pkg::data_t   frame_data
);
  import spi_frame_pkg::*;

  // bit counter compare points
  localparam logic [5:0] CMD_LAST   = 6'(CMD_BITS - 1);
  localparam logic [5:0] CMD_DONE   = 6'(CMD_BITS);
  localparam logic [5:0] FRAME_LAST = 6'(FRAME_BITS - 1);
  localparam logic [5:0] FRAME_DONE = 6'(FRAME_BITS);

  // sclk needs a third stage for edge detection
  logic [2:0] sclk_q;
  logic [1:0] cs_q;
  logic [1:0] sdi_q;

  logic sclk_rise;
  logic sclk_fall;
  logic cs_active;
  logic sdi_bit;
  logic shift_en;

  // bits 1 to 40 counted, saturates at 40
  logic [5:0] bit_cnt;
  logic [FRAME_BITS-1:0] in_shift;
  logic [FRAME_BITS-1:0] frame_word;
  data_t out_shift;

  // command byte as seen at bit 8 and at bit 40
  logic [CMD_BITS-1:0] early_cmd;
  logic [CMD_BITS-1:0] full_cmd;

  // edges are taken after the second sync stage
  assign sclk_rise = sclk_q[1] & ~sclk_q[2];
  assign sclk_fall = ~sclk_q[1] & sclk_q[2];
  assign cs_active = ~cs_q[1];
  assign sdi_bit   = sdi_q[1];

  // one bit accepted per rising edge, extra bits past 40 dropped
  assign shift_en   = cs_active & sclk_rise & (bit_cnt != FRAME_DONE);
  assign frame_word = {in_shift[FRAME_BITS-2:0], sdi_bit};

  assign early_cmd = frame_word[CMD_BITS-1:0];
  assign full_cmd  = frame_word[FRAME_BITS-1:FRAME_CMD_LSB];

  // readback word leaves MSB first
  assign spi_sdo = out_shift[DATA_BITS-1];

  // pin synchronizers
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sclk_q <= 3'b000;
      // chip select idles high
      cs_q   <= 2'b11;
      sdi_q  <= 2'b00;
    end
    else
    begin
      sclk_q <= {sclk_q[1:0], spi_clk};
      cs_q   <= {cs_q[0], spi_cs_n};
      sdi_q  <= {sdi_q[0], spi_sdi};
    end
  end

  // bit counter, strobes and readback shifter
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      bit_cnt      <= '0;
      cmd_strobe   <= 1'b0;
      frame_strobe <= 1'b0;
      out_shift    <= '0;
    end
    else
    begin
      // strobes last a single clk
      cmd_strobe   <= 1'b0;
      frame_strobe <= 1'b0;
      if (!cs_active)
      begin
        // deselect aborts any partial frame
        bit_cnt   <= '0;
        out_shift <= '0;
      end
      else
      begin
        if (shift_en)
        begin
          bit_cnt <= bit_cnt + 6'd1;
          // address complete at bit 8
          if (bit_cnt == CMD_LAST)
            cmd_strobe <= 1'b1;
          // whole frame complete at bit 40
          if (bit_cnt == FRAME_LAST)
            frame_strobe <= 1'b1;
        end
        if (sclk_fall)
        begin
          // falling edge after bit 8 loads the old register value
          if (bit_cnt == CMD_DONE)
            out_shift <= rd_data;
          // later falling edges move the next bit onto sdo
          else if (bit_cnt > CMD_DONE)
            out_shift <= {out_shift[DATA_BITS-2:0], 1'b0};
        end
      end
    end
  end

  // input shifter and frame fields
  always_ff @(posedge clk)
  begin
    if (!cs_active)
      in_shift <= '0;
    else if (shift_en)
    begin
      in_shift <= frame_word;
      // address held from bit 8 for the rest of the frame
      if (bit_cnt == CMD_LAST)
        cmd_addr <= early_cmd[CMD_ADDR_MSB:CMD_ADDR_LSB];
      if (bit_cnt == FRAME_LAST)
      begin
        frame_read <= full_cmd[CMD_READ_BIT];
        frame_op   <= spi_op_e'(full_cmd[CMD_OP_MSB:CMD_OP_LSB]);
        frame_data <= frame_word[DATA_BITS-1:0];
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/reg_map_pkg.sv
// register map: addresses, reset values and the readback pattern for unmapped addresses
`default_nettype none

package reg_map_pkg;

  // register addresses on the five-bit address field
  localparam spi_frame_pkg::addr_t REG_LED     = 5'd7;
  localparam spi_frame_pkg::addr_t REG_SPI_MUX = 5'd8;
  localparam spi_frame_pkg::addr_t REG_4094    = 5'd9;
  localparam spi_frame_pkg::addr_t REG_MODE    = 5'd12;
  localparam spi_frame_pkg::addr_t REG_DIRECT  = 5'd14;

  // led pattern at power up, a visible alternating test vector
  localparam spi_frame_pkg::data_t RST_LED = 32'h00aaaaaf;

  // no spi device selected on the mux
  localparam spi_frame_pkg::data_t RST_SPI_MUX = 32'h0000_0000;

  // 4094 chain outputs all low
  localparam spi_frame_pkg::data_t RST_4094 = 32'h0000_0000;

  // default operating mode
  localparam spi_frame_pkg::data_t RST_MODE = 32'h0000_0000;

  // direct control lines inactive
  localparam spi_frame_pkg::data_t RST_DIRECT = 32'h0000_0000;

  // returned for any address that holds no register
  localparam spi_frame_pkg::data_t UNMAPPED_READ = 32'h0f0f0f0f;

endpackage

`default_nettype wire

// File: hdl/spi_frame_pkg.sv
// SPI frame layout: widths, word types, opcode enum and command byte field positions
`default_nettype none

package spi_frame_pkg;

  // one frame is a command byte followed by a 32-bit data word
  localparam int FRAME_BITS = 40;
  localparam int CMD_BITS   = 8;
  localparam int DATA_BITS  = 32;
  localparam int ADDR_BITS  = 5;

  typedef logic [DATA_BITS-1:0] data_t;
  typedef logic [ADDR_BITS-1:0] addr_t;

  // bitwise update applied to the addressed register
  typedef enum logic [1:0] {
    op_write  = 2'd0,
    op_set    = 2'd1,
    op_clear  = 2'd2,
    op_toggle = 2'd3
  } spi_op_e;

  // field positions inside the command byte, sent MSB first
  // read flag set means the frame only reads
  localparam int CMD_READ_BIT = 7;
  localparam int CMD_OP_MSB   = 6;
  localparam int CMD_OP_LSB   = 5;
  localparam int CMD_ADDR_MSB = 4;
  localparam int CMD_ADDR_LSB = 0;

  // command byte sits above the data word in a complete frame
  localparam int FRAME_CMD_LSB = DATA_BITS;

endpackage

`default_nettype wire
